//--- axi_isolate.f
hdl/axi_chan_pkg.sv
hdl/isolate_pkg.sv
hdl/pending_counter.sv
hdl/write_isolator.sv
hdl/read_isolator.sv
hdl/axi_isolate.sv
verification/tb_axi_isolate.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the AXI isolator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_axi_isolate -f axi_isolate.f -o tb_axi_isolate
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_axi_isolate)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx 'TESTBENCH PASSED'; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- verification/tb_axi_isolate.sv
// Directed testbench for the AXI4 isolator covering reset, pass-through, limits, drain and hold
`timescale 1ns/1ps

module tb_axi_isolate
  import axi_chan_pkg::*;
();

  localparam int unsigned NumPending = 4;
  // Rough length of all tests, the timeout leaves five times that
  localparam int TestCycles    = 400;
  localparam int TimeoutCycles = 5 * TestCycles;

  // Wide enough for the request struct
  typedef logic [159:0] cmp_t;

  logic      clk_i = 1'b0;
  logic      reset_i;
  axi_req_t  slv_req;
  axi_resp_t slv_resp;
  axi_req_t  mst_req;
  axi_resp_t mst_resp;
  logic      isolate;
  logic      isolated;

  logic [31:0] rng_state   = 32'hd620_e375;
  int          error_count = 0;
  int          check_count = 0;
  int          cycle_count = 0;

  // 40 ns period
  always #20 clk_i = ~clk_i;

  axi_isolate #(
    .NumPending (NumPending)
  ) i_axi_isolate (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp),
    .mst_req_o  (mst_req),
    .mst_resp_i (mst_resp),
    .isolate_i  (isolate),
    .isolated_o (isolated)
  );

  // Run limit
  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TimeoutCycles) begin
      $display("Timeout: tests still running after %0d cycles", TimeoutCycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Random payloads, single-beat bursts, response readies high
  function automatic axi_req_t random_req(input logic valid);
    logic [159:0] bits;
    axi_req_t     req;
    bits = {next_rand(), next_rand(), next_rand(), next_rand(), next_rand()};
    req = bits[$bits(axi_req_t)-1:0];
    req.aw.len   = '0;
    req.ar.len   = '0;
    req.w.last   = 1'b1;
    req.aw_valid = valid;
    req.w_valid  = valid;
    req.ar_valid = valid;
    req.b_ready  = 1'b1;
    req.r_ready  = 1'b1;
    return req;
  endfunction

  // Random responses, address and data readies high
  function automatic axi_resp_t random_resp(input logic valid);
    logic [63:0] bits;
    axi_resp_t   resp;
    bits = {next_rand(), next_rand()};
    resp = bits[$bits(axi_resp_t)-1:0];
    resp.r.last   = 1'b1;
    resp.aw_ready = 1'b1;
    resp.w_ready  = 1'b1;
    resp.ar_ready = 1'b1;
    resp.b_valid  = valid;
    resp.r_valid  = valid;
    return resp;
  endfunction

  task automatic step();
    @(posedge clk_i);
    @(negedge clk_i);
  endtask

  // No requests, master side ready
  task automatic drive_idle();
    slv_req           = '0;
    mst_resp          = '0;
    mst_resp.aw_ready = 1'b1;
    mst_resp.w_ready  = 1'b1;
    mst_resp.ar_ready = 1'b1;
  endtask

  task automatic compare(input string name, input cmp_t actual, input cmp_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  // Bounded wait on the isolated level
  task automatic wait_isolated(input logic level, input int max_edges);
    int edges;
    edges = 0;
    while (isolated !== level && edges < max_edges) begin
      step();
      edges++;
    end
    check_count++;
    if (isolated !== level) begin
      error_count++;
      $display("isolated_o did not reach %0b within %0d clock edges", level, max_edges);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////
  // Out of reset everything toward the master is silent
  task automatic reset_isolation();
    repeat (3) begin
      slv_req  = random_req(1'b1);
      mst_resp = random_resp(1'b1);
      #1;
      compare("isolated_o", cmp_t'(isolated), cmp_t'(1));
      compare("mst_req_o", cmp_t'(mst_req), cmp_t'(0));
      compare("slv_resp_o", cmp_t'(slv_resp), cmp_t'(0));
      step();
    end
    drive_idle();
  endtask

  // Every beat closes in its own cycle, so counters stay at zero
  task automatic pass_through();
    isolate = 1'b0;
    step();
    compare("isolated_o", cmp_t'(isolated), cmp_t'(0));
    repeat (4) begin
      slv_req  = random_req(1'b1);
      mst_resp = random_resp(1'b1);
      #1;
      compare("mst_req_o", cmp_t'(mst_req), cmp_t'(slv_req));
      compare("slv_resp_o", cmp_t'(slv_resp), cmp_t'(mst_resp));
      step();
    end
    drive_idle();
  endtask

  task automatic pending_limit();
    // Write side, W burst sent along with each AW
    repeat (NumPending) begin
      slv_req = random_req(1'b0);
      slv_req.aw_valid = 1'b1;
      slv_req.w_valid  = 1'b1;
      #1;
      compare("mst aw_valid", cmp_t'(mst_req.aw_valid), cmp_t'(1));
      step();
    end
    slv_req = random_req(1'b0);
    slv_req.aw_valid  = 1'b1;
    slv_req.w_valid   = 1'b1;
    mst_resp.b_valid  = 1'b1;
    #1;
    compare("mst aw_valid", cmp_t'(mst_req.aw_valid), cmp_t'(0));
    compare("slv aw_ready", cmp_t'(slv_resp.aw_ready), cmp_t'(0));
    compare("mst w_valid", cmp_t'(mst_req.w_valid), cmp_t'(0));
    compare("slv b_valid", cmp_t'(slv_resp.b_valid), cmp_t'(1));
    step();
    // One B freed a slot
    mst_resp.b_valid = 1'b0;
    #1;
    compare("mst aw_valid", cmp_t'(mst_req.aw_valid), cmp_t'(1));
    compare("mst aw", cmp_t'(mst_req.aw), cmp_t'(slv_req.aw));
    step();
    slv_req.aw_valid = 1'b0;
    slv_req.w_valid  = 1'b0;
    mst_resp.b_valid = 1'b1;
    repeat (NumPending) step();
    drive_idle();

    // Read side
    repeat (NumPending) begin
      slv_req = random_req(1'b0);
      slv_req.ar_valid = 1'b1;
      #1;
      compare("mst ar_valid", cmp_t'(mst_req.ar_valid), cmp_t'(1));
      step();
    end
    slv_req = random_req(1'b0);
    slv_req.ar_valid = 1'b1;
    mst_resp = random_resp(1'b0);
    mst_resp.r_valid = 1'b1;
    #1;
    compare("mst ar_valid", cmp_t'(mst_req.ar_valid), cmp_t'(0));
    compare("slv ar_ready", cmp_t'(slv_resp.ar_ready), cmp_t'(0));
    compare("slv r_valid", cmp_t'(slv_resp.r_valid), cmp_t'(1));
    step();
    mst_resp.r_valid = 1'b0;
    #1;
    compare("mst ar_valid", cmp_t'(mst_req.ar_valid), cmp_t'(1));
    compare("mst ar", cmp_t'(mst_req.ar), cmp_t'(slv_req.ar));
    step();
    slv_req.ar_valid = 1'b0;
    mst_resp.r_valid = 1'b1;
    repeat (NumPending) step();
    drive_idle();
  endtask

  task automatic w_gating();
    slv_req = random_req(1'b0);
    slv_req.w.last  = 1'b0;
    slv_req.w_valid = 1'b1;
    #1;
    compare("mst w_valid", cmp_t'(mst_req.w_valid), cmp_t'(0));
    compare("slv w_ready", cmp_t'(slv_resp.w_ready), cmp_t'(0));
    compare("mst w", cmp_t'(mst_req.w), cmp_t'(0));
    step();
    // Two-beat burst owed after this AW
    slv_req.aw_valid = 1'b1;
    slv_req.aw.len   = 8'd1;
    slv_req.w_valid  = 1'b0;
    #1;
    compare("mst aw_valid", cmp_t'(mst_req.aw_valid), cmp_t'(1));
    step();
    slv_req.aw_valid = 1'b0;
    slv_req.w_valid  = 1'b1;
    for (int beat = 0; beat < 2; beat++) begin
      slv_req.w.data = next_rand();
      slv_req.w.last = (beat == 1);
      #1;
      compare("mst w_valid", cmp_t'(mst_req.w_valid), cmp_t'(1));
      compare("slv w_ready", cmp_t'(slv_resp.w_ready), cmp_t'(1));
      compare("mst w", cmp_t'(mst_req.w), cmp_t'(slv_req.w));
      step();
    end
    slv_req.w.last = 1'b0;
    #1;
    compare("mst w_valid", cmp_t'(mst_req.w_valid), cmp_t'(0));
    compare("slv w_ready", cmp_t'(slv_resp.w_ready), cmp_t'(0));
    // B closes the write
    slv_req.w_valid  = 1'b0;
    mst_resp.b_valid = 1'b1;
    step();
    drive_idle();
  endtask

  task automatic drain_then_isolate();
    repeat (2) begin
      slv_req = random_req(1'b0);
      slv_req.ar_valid = 1'b1;
      step();
    end
    drive_idle();
    isolate = 1'b1;
    step();
    // New AR blocked while both R bursts return
    slv_req = random_req(1'b0);
    slv_req.ar_valid = 1'b1;
    mst_resp = random_resp(1'b0);
    mst_resp.r_valid = 1'b1;
    for (int beat = 0; beat < 2; beat++) begin
      mst_resp.r.data = next_rand();
      #1;
      compare("isolated_o", cmp_t'(isolated), cmp_t'(0));
      compare("mst ar_valid", cmp_t'(mst_req.ar_valid), cmp_t'(0));
      compare("slv ar_ready", cmp_t'(slv_resp.ar_ready), cmp_t'(0));
      compare("slv r_valid", cmp_t'(slv_resp.r_valid), cmp_t'(1));
      compare("slv r", cmp_t'(slv_resp.r), cmp_t'(mst_resp.r));
      step();
    end
    drive_idle();
    wait_isolated(1'b1, 1);
    slv_req = random_req(1'b1);
    #1;
    compare("mst_req_o", cmp_t'(mst_req), cmp_t'(0));
    step();
    drive_idle();
  endtask

  task automatic hold_and_release();
    isolate = 1'b0;
    step();
    compare("isolated_o", cmp_t'(isolated), cmp_t'(0));
    // Stalled AR, isolation requested mid-handshake
    slv_req = random_req(1'b0);
    slv_req.ar_valid  = 1'b1;
    mst_resp.ar_ready = 1'b0;
    #1;
    compare("mst ar_valid", cmp_t'(mst_req.ar_valid), cmp_t'(1));
    step();
    isolate = 1'b1;
    repeat (3) begin
      #1;
      compare("mst ar_valid", cmp_t'(mst_req.ar_valid), cmp_t'(1));
      compare("mst ar", cmp_t'(mst_req.ar), cmp_t'(slv_req.ar));
      compare("isolated_o", cmp_t'(isolated), cmp_t'(0));
      step();
    end
    mst_resp.ar_ready = 1'b1;
    #1;
    compare("slv ar_ready", cmp_t'(slv_resp.ar_ready), cmp_t'(1));
    step();
    drive_idle();
    step();
    compare("isolated_o", cmp_t'(isolated), cmp_t'(0));
    // Last R of the held read
    mst_resp.r_valid = 1'b1;
    mst_resp.r.last  = 1'b1;
    slv_req.r_ready  = 1'b1;
    #1;
    compare("slv r_valid", cmp_t'(slv_resp.r_valid), cmp_t'(1));
    step();
    drive_idle();
    wait_isolated(1'b1, 1);
    isolate = 1'b0;
    step();
    compare("isolated_o", cmp_t'(isolated), cmp_t'(0));
    slv_req = random_req(1'b0);
    slv_req.aw_valid = 1'b1;
    slv_req.w_valid  = 1'b1;
    #1;
    compare("mst aw_valid", cmp_t'(mst_req.aw_valid), cmp_t'(1));
    compare("mst aw", cmp_t'(mst_req.aw), cmp_t'(slv_req.aw));
    compare("mst w", cmp_t'(mst_req.w), cmp_t'(slv_req.w));
    compare("mst w_valid", cmp_t'(mst_req.w_valid), cmp_t'(1));
    step();
    slv_req.aw_valid = 1'b0;
    slv_req.w_valid  = 1'b0;
    mst_resp = random_resp(1'b0);
    mst_resp.b_valid = 1'b1;
    #1;
    compare("slv b", cmp_t'(slv_resp.b), cmp_t'(mst_resp.b));
    compare("slv b_valid", cmp_t'(slv_resp.b_valid), cmp_t'(1));
    step();
    drive_idle();
  endtask

  ////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////
  initial begin
    reset_i = 1'b1;
    isolate = 1'b1;
    drive_idle();
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    reset_isolation();
    pass_through();
    pending_limit();
    w_gating();
    drain_then_isolate();
    hold_and_release();
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/axi_isolate.sv
// AXI4 bus isolator joining the write and read isolators of one link
`timescale 1ns/1ps

module axi_isolate
  import axi_chan_pkg::*;
#(
  parameter int unsigned NumPending = 16
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  axi_req_t  slv_req_i,
  output axi_resp_t slv_resp_o,
  output axi_req_t  mst_req_o,
  input  axi_resp_t mst_resp_i,
  input  logic      isolate_i,
  output logic      isolated_o
);

  logic wr_isolated;
  logic rd_isolated;

  // AW, W and B fields
  write_isolator #(
    .NumPending (NumPending)
  ) i_write_isolator (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .slv_req_i      (slv_req_i),
    .mst_resp_i     (mst_resp_i),
    .isolate_i      (isolate_i),
    .mst_aw_o       (mst_req_o.aw),
    .mst_aw_valid_o (mst_req_o.aw_valid),
    .mst_w_o        (mst_req_o.w),
    .mst_w_valid_o  (mst_req_o.w_valid),
    .mst_b_ready_o  (mst_req_o.b_ready),
    .slv_aw_ready_o (slv_resp_o.aw_ready),
    .slv_w_ready_o  (slv_resp_o.w_ready),
    .slv_b_o        (slv_resp_o.b),
    .slv_b_valid_o  (slv_resp_o.b_valid),
    .isolated_o     (wr_isolated)
  );

  // AR and R fields
  read_isolator #(
    .NumPending (NumPending)
  ) i_read_isolator (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .slv_req_i      (slv_req_i),
    .mst_resp_i     (mst_resp_i),
    .isolate_i      (isolate_i),
    .mst_ar_o       (mst_req_o.ar),
    .mst_ar_valid_o (mst_req_o.ar_valid),
    .mst_r_ready_o  (mst_req_o.r_ready),
    .slv_ar_ready_o (slv_resp_o.ar_ready),
    .slv_r_o        (slv_resp_o.r),
    .slv_r_valid_o  (slv_resp_o.r_valid),
    .isolated_o     (rd_isolated)
  );

  // Isolated only once both sides have drained
  assign isolated_o = wr_isolated && rd_isolated;

endmodule

//--- hdl/read_isolator.sv
// Read-side isolator gating AR and R with outstanding-read tracking
`timescale 1ns/1ps

module read_isolator
  import axi_chan_pkg::*, isolate_pkg::*;
#(
  parameter int unsigned NumPending = 16
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  axi_req_t  slv_req_i,
  input  axi_resp_t mst_resp_i,
  input  logic      isolate_i,
  output ar_chan_t  mst_ar_o,
  output logic      mst_ar_valid_o,
  output logic      mst_r_ready_o,
  output logic      slv_ar_ready_o,
  output r_chan_t   slv_r_o,
  output logic      slv_r_valid_o,
  output logic      isolated_o
);

  isolate_state_e state_q, state_d;

  logic ar_inc, ar_dec, ar_full, ar_empty;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= Isolate;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d        = state_q;
    mst_ar_o       = slv_req_i.ar;
    mst_ar_valid_o = slv_req_i.ar_valid;
    slv_ar_ready_o = mst_resp_i.ar_ready;
    slv_r_o        = mst_resp_i.r;
    slv_r_valid_o  = mst_resp_i.r_valid;
    mst_r_ready_o  = slv_req_i.r_ready;
    unique case (state_q)
      Normal: begin
        if (ar_full) begin
          mst_ar_valid_o = 1'b0;
          slv_ar_ready_o = 1'b0;
          if (isolate_i) begin
            state_d = Drain;
          end
        end else if (slv_req_i.ar_valid && !mst_resp_i.ar_ready) begin
          state_d = Hold;
        end else if (isolate_i) begin
          state_d = Drain;
        end
      end
      Hold: begin
        // AXI forbids dropping valid before ready
        mst_ar_valid_o = 1'b1;
        if (mst_resp_i.ar_ready) begin
          state_d = isolate_i ? Drain : Normal;
        end
      end
      Drain: begin
        mst_ar_o       = '0;
        mst_ar_valid_o = 1'b0;
        slv_ar_ready_o = 1'b0;
        if (ar_empty) begin
          state_d = Isolate;
        end
      end
      Isolate: begin
        mst_ar_o       = '0;
        mst_ar_valid_o = 1'b0;
        slv_ar_ready_o = 1'b0;
        slv_r_o        = '0;
        slv_r_valid_o  = 1'b0;
        mst_r_ready_o  = 1'b0;
        if (!isolate_i) begin
          state_d = Normal;
        end
      end
      default: begin
        state_d = Isolate;
      end
    endcase
  end

  // Counted once per read, closed by the last R beat
  assign ar_inc = mst_ar_valid_o && (state_q == Normal);
  assign ar_dec = mst_resp_i.r_valid && mst_r_ready_o && mst_resp_i.r.last;

  pending_counter #(
    .NumPending (NumPending)
  ) i_ar_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .inc_i   (ar_inc),
    .dec_i   (ar_dec),
    .full_o  (ar_full),
    .empty_o (ar_empty)
  );

  assign isolated_o = (state_q == Isolate);

  // A stalled AR stays presented into the next cycle
  hold_valid_chk: assert property (@(posedge clk_i) disable iff (reset_i)
    (mst_ar_valid_o && !mst_resp_i.ar_ready) |=> mst_ar_valid_o)
    else $error("master ar_valid dropped without a transfer");

endmodule

//--- hdl/write_isolator.sv
// Write-side isolator gating AW, W and B with outstanding-burst tracking
`timescale 1ns/1ps

module write_isolator
  import axi_chan_pkg::*, isolate_pkg::*;
#(
  parameter int unsigned NumPending = 16
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  axi_req_t  slv_req_i,
  input  axi_resp_t mst_resp_i,
  input  logic      isolate_i,
  output aw_chan_t  mst_aw_o,
  output logic      mst_aw_valid_o,
  output w_chan_t   mst_w_o,
  output logic      mst_w_valid_o,
  output logic      mst_b_ready_o,
  output logic      slv_aw_ready_o,
  output logic      slv_w_ready_o,
  output b_chan_t   slv_b_o,
  output logic      slv_b_valid_o,
  output logic      isolated_o
);

  isolate_state_e state_q, state_d;

  logic aw_inc, aw_dec, aw_full, aw_empty;
  logic w_dec, w_full, w_empty;
  logic w_open;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // Start isolated until isolate_i is released
      state_q <= Isolate;
    end else begin
      state_q <= state_d;
    end
  end

  ////////////////////////////////////////
  // AW and B state machine
  ////////////////////////////////////////
  always_comb begin
    state_d        = state_q;
    // Pass-through by default
    mst_aw_o       = slv_req_i.aw;
    mst_aw_valid_o = slv_req_i.aw_valid;
    slv_aw_ready_o = mst_resp_i.aw_ready;
    slv_b_o        = mst_resp_i.b;
    slv_b_valid_o  = mst_resp_i.b_valid;
    mst_b_ready_o  = slv_req_i.b_ready;
    unique case (state_q)
      Normal: begin
        if (aw_full || w_full) begin
          // Limit reached, no new AW
          mst_aw_valid_o = 1'b0;
          slv_aw_ready_o = 1'b0;
          if (isolate_i) begin
            state_d = Drain;
          end
        end else if (slv_req_i.aw_valid && !mst_resp_i.aw_ready) begin
          // Stalled handshake must finish first
          state_d = Hold;
        end else if (isolate_i) begin
          state_d = Drain;
        end
      end
      Hold: begin
        mst_aw_valid_o = 1'b1;
        if (mst_resp_i.aw_ready) begin
          state_d = isolate_i ? Drain : Normal;
        end
      end
      Drain: begin
        mst_aw_o       = '0;
        mst_aw_valid_o = 1'b0;
        slv_aw_ready_o = 1'b0;
        // B responses keep flowing until everything is closed
        if (aw_empty && w_empty) begin
          state_d = Isolate;
        end
      end
      Isolate: begin
        mst_aw_o       = '0;
        mst_aw_valid_o = 1'b0;
        slv_aw_ready_o = 1'b0;
        slv_b_o        = '0;
        slv_b_valid_o  = 1'b0;
        mst_b_ready_o  = 1'b0;
        if (!isolate_i) begin
          state_d = Normal;
        end
      end
      default: begin
        state_d = Isolate;
      end
    endcase
  end

  ////////////////////////////////////////
  // W gating and counters
  ////////////////////////////////////////
  // Count only on the first cycle of a request, Hold does not recount
  assign aw_inc = mst_aw_valid_o && (state_q == Normal);
  assign aw_dec = mst_resp_i.b_valid && mst_b_ready_o;

  // W open while a burst is owed, or unlocked by the AW counted this cycle
  assign w_open        = !w_empty || aw_inc;
  assign mst_w_o       = w_open ? slv_req_i.w : '0;
  assign mst_w_valid_o = w_open && slv_req_i.w_valid;
  assign slv_w_ready_o = w_open && mst_resp_i.w_ready;
  assign w_dec         = mst_w_valid_o && mst_resp_i.w_ready && slv_req_i.w.last;

  pending_counter #(
    .NumPending (NumPending)
  ) i_aw_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .inc_i   (aw_inc),
    .dec_i   (aw_dec),
    .full_o  (aw_full),
    .empty_o (aw_empty)
  );

  pending_counter #(
    .NumPending (NumPending)
  ) i_w_counter (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .inc_i   (aw_inc),
    .dec_i   (w_dec),
    .full_o  (w_full),
    .empty_o (w_empty)
  );

  assign isolated_o = (state_q == Isolate);

  // Isolate held until isolate_i falls and no W beat leaks meanwhile
  stay_isolated_chk: assert property (@(posedge clk_i) disable iff (reset_i)
    (state_q == Isolate && isolate_i) |=> (state_q == Isolate && !mst_w_valid_o))
    else $error("write isolator left Isolate or forwarded W while isolate_i high");

endmodule

//--- hdl/pending_counter.sv
// Outstanding-transaction counter reporting full and empty
`timescale 1ns/1ps

module pending_counter #(
  parameter int unsigned NumPending = 16
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic inc_i,
  input  logic dec_i,
  output logic full_o,
  output logic empty_o
);

  // Zero through NumPending inclusive
  localparam int unsigned CntWidth = $clog2(NumPending + 1);

  logic [CntWidth-1:0] count_q;

  // Simultaneous inc and dec leave the count alone
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
    end else if (inc_i && !dec_i) begin
      count_q <= count_q + 1'b1;
    end else if (dec_i && !inc_i) begin
      count_q <= count_q - 1'b1;
    end
  end

  assign full_o  = (count_q == CntWidth'(NumPending));
  assign empty_o = (count_q == '0);

  // The isolator must cut requests once the limit is reached
  overflow_chk: assert property (@(posedge clk_i) disable iff (reset_i)
    (full_o && inc_i) |-> dec_i)
    else $error("pending counter incremented while full");

  // A response without an open transaction
  underflow_chk: assert property (@(posedge clk_i) disable iff (reset_i)
    (empty_o && dec_i) |-> inc_i)
    else $error("pending counter decremented while empty");

endmodule

//--- hdl/isolate_pkg.sv
// Isolation package with the state encoding shared by the write and read isolators
package isolate_pkg;

  // Normal    requests pass straight through
  // Hold      valid kept high until the started handshake completes
  // Drain     new requests cut, waiting for open transactions
  // Isolate   every master-side request silenced
  typedef enum logic [1:0] {
    Normal,
    Hold,
    Drain,
    Isolate
  } isolate_state_e;

endpackage

//--- hdl/axi_chan_pkg.sv
// AXI4 channel package with bus widths, response codes and channel structs
package axi_chan_pkg;

  ////////////////////////////////////////
  // Bus widths
  ////////////////////////////////////////
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  // One strobe bit per data byte
  localparam int unsigned StrbWidth = DataWidth / 8;
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned LenWidth  = 8;

  // AXI response encoding
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

  ////////////////////////////////////////
  // Channel payloads
  ////////////////////////////////////////
  // Write address
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
  } aw_chan_t;

  // Read address
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [AddrWidth-1:0] addr;
    logic [LenWidth-1:0]  len;
  } ar_chan_t;

  // Write data beat
  typedef struct packed {
    logic [DataWidth-1:0] data;
    logic [StrbWidth-1:0] strb;
    logic                 last;
  } w_chan_t;

  // Write response
  typedef struct packed {
    logic [IdWidth-1:0] id;
    axi_resp_e          resp;
  } b_chan_t;

  // Read data beat
  typedef struct packed {
    logic [IdWidth-1:0]   id;
    logic [DataWidth-1:0] data;
    axi_resp_e            resp;
    logic                 last;
  } r_chan_t;

  // Manager to subordinate bundle
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Subordinate to manager bundle
  typedef struct packed {
    logic    aw_ready;
    logic    w_ready;
    b_chan_t b;
    logic    b_valid;
    logic    ar_ready;
    r_chan_t r;
    logic    r_valid;
  } axi_resp_t;

endpackage
